// File: hdl/ofdm_pkg.sv
package ofdm_pkg;

    localparam int FFT_LEN        = 16;
    localparam int SAMPLE_W       = 16;
    localparam int BIN_W          = SAMPLE_W + 4 + 2;  // 4 growth bits and 2 bits of headroom
    localparam int TWIDDLE_W      = 16;
    localparam int TWIDDLE_FRAC   = 14;                // Q1.14, so +1 is 16384
    localparam int CP_LEN_W       = 5;
    localparam int CP_LEN_DEFAULT = 16;
    localparam int SYM_W          = 4;
    localparam int META_DEPTH     = 4;
    localparam int META_PTR_W     = $clog2(META_DEPTH);
    localparam int OUT_CREDITS    = 4;
    localparam int CREDIT_W       = $clog2(OUT_CREDITS + 1);
    localparam int CFG_ADDR_W     = 1;
    localparam int CFG_DATA_W     = 8;
    localparam int BIN_IDX_W      = $clog2(FFT_LEN);
    localparam int BAND_LEN_W     = BIN_IDX_W + 1;     // a band may hold all 16 bins
    localparam int BAND_START_RST = 4;
    localparam int BAND_LEN_RST   = 8;

    typedef logic [BIN_IDX_W-1:0]  bin_idx_t;
    typedef logic [BAND_LEN_W-1:0] band_len_t;
    typedef logic [CFG_DATA_W-1:0] cfg_data_t;

    typedef struct packed {
        logic signed [SAMPLE_W-1:0] im;
        logic signed [SAMPLE_W-1:0] re;
    } sample_t;

    typedef struct packed {
        logic [SYM_W-1:0]    sym;
        logic [CP_LEN_W-1:0] cp_len;
    } in_user_t;

    typedef struct packed {
        logic signed [BIN_W-1:0] im;
        logic signed [BIN_W-1:0] re;
    } bin_t;

    typedef struct packed {
        bin_t     bin;
        bin_idx_t idx;
    } dft_out_t;

    typedef struct packed {
        bin_t             bin;
        logic [SYM_W-1:0] sym;
        bin_idx_t         idx;
        logic             last;
    } out_beat_t;

    typedef struct packed {
        logic signed [TWIDDLE_W-1:0] im;
        logic signed [TWIDDLE_W-1:0] re;
    } twiddle_t;

    typedef enum logic [1:0] {SKIP_CP, TAKE_SYMBOL, SKIP_END} cp_state_e;

    typedef enum logic [CFG_ADDR_W-1:0] {REG_BAND_START, REG_BAND_LEN} cfg_reg_e;

    // cosine of 2*pi*k/16 in Q1.14, rounded to nearest
    function automatic logic signed [TWIDDLE_W-1:0] cos_q14(bin_idx_t k);
        case (k)
            4'd0:         return 16'sd16384;
            4'd1, 4'd15:  return 16'sd15137;
            4'd2, 4'd14:  return 16'sd11585;
            4'd3, 4'd13:  return 16'sd6270;
            4'd4, 4'd12:  return 16'sd0;
            4'd5, 4'd11:  return -16'sd6270;
            4'd6, 4'd10:  return -16'sd11585;
            4'd7, 4'd9:   return -16'sd15137;
            default:      return -16'sd16384;   // k is 8
        endcase
    endfunction

    // e^(-j*2*pi*k/16) as the cosine and minus sine pair
    function automatic twiddle_t twiddle(bin_idx_t k);
        twiddle_t tw;
        tw.re = cos_q14(k);
        tw.im = -cos_q14(k - 4'd4);  // sin(x) equals cos(x - pi/2)
        return tw;
    endfunction

endpackage

// File: hdl/cp_remover.sv
`timescale 1ns/100ps

module cp_remover (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  logic                       in_valid_i,
    input  ofdm_pkg::sample_t          in_data_i,
    input  ofdm_pkg::in_user_t         in_user_i,
    input  logic                       in_last_i,
    output logic                       smp_valid_o,
    output ofdm_pkg::sample_t          smp_data_o,
    output logic                       smp_first_o,
    output logic                       meta_push_o,
    output logic [ofdm_pkg::SYM_W-1:0] meta_sym_o
);

    ofdm_pkg::cp_state_e           state;
    logic [ofdm_pkg::CP_LEN_W-1:0] skip_cnt;   // starts at half the prefix, ends at its length
    ofdm_pkg::bin_idx_t            smp_cnt;    // samples taken so far in this symbol
    logic [ofdm_pkg::CP_LEN_W-1:0] cp_len;
    logic                          skip_done;
    logic                          take;

    assign cp_len = in_user_i.cp_len;  // the prefix length always comes from the current beat
    assign skip_done = ({1'b0, skip_cnt} + 1'b1) >= {1'b0, cp_len};
    assign take = in_valid_i && (state == ofdm_pkg::TAKE_SYMBOL);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            state    <= ofdm_pkg::SKIP_CP;
            skip_cnt <= ofdm_pkg::CP_LEN_DEFAULT[ofdm_pkg::CP_LEN_W:1];  // half the default
            smp_cnt  <= '0;
        end else if (in_valid_i) begin
            case (state)
                ofdm_pkg::SKIP_CP: begin
                    smp_cnt <= '0;
                    if (skip_done) begin
                        state <= ofdm_pkg::TAKE_SYMBOL;
                    end else begin
                        skip_cnt <= skip_cnt + 1'b1;
                    end
                end
                ofdm_pkg::TAKE_SYMBOL: begin
                    smp_cnt <= smp_cnt + 1'b1;
                    if (&smp_cnt) begin  // 16th sample of the symbol
                        // the next window opens half a prefix early
                        skip_cnt <= cp_len >> 1;
                        state <= in_last_i ? ofdm_pkg::SKIP_CP : ofdm_pkg::SKIP_END;
                    end
                end
                ofdm_pkg::SKIP_END: begin
                    if (in_last_i) begin
                        state <= ofdm_pkg::SKIP_CP;  // repetition ends with the input's last beat
                    end
                end
                default: state <= ofdm_pkg::SKIP_CP;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            smp_valid_o <= 1'b0;
            smp_first_o <= 1'b0;
        end else begin
            smp_valid_o <= take;
            smp_first_o <= take && (smp_cnt == '0);
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            smp_data_o <= in_data_i;
            meta_sym_o <= in_user_i.sym;
        end
    end

    // the symbol number enters the FIFO together with the first sample
    assign meta_push_o = smp_first_o;

endmodule

// File: hdl/symbol_meta_fifo.sv
`timescale 1ns/100ps

module symbol_meta_fifo (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  logic                       push_i,
    input  logic [ofdm_pkg::SYM_W-1:0] push_data_i,
    input  logic                       pop_i,
    output logic [ofdm_pkg::SYM_W-1:0] pop_data_o,
    output logic                       empty_o
);

    logic [ofdm_pkg::SYM_W-1:0]      mem [ofdm_pkg::META_DEPTH];
    logic [ofdm_pkg::META_PTR_W-1:0] wr_ptr;
    logic [ofdm_pkg::META_PTR_W-1:0] rd_ptr;
    logic [ofdm_pkg::META_PTR_W:0]   count;
    logic                            do_push;
    logic                            do_pop;

    assign empty_o = (count == '0);
    // depth is a power of two, so the count's top bit alone marks full
    assign do_push = push_i && !count[ofdm_pkg::META_PTR_W];
    assign do_pop = pop_i && !empty_o;
    assign pop_data_o = mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;  // pointers wrap on their own
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

endmodule

// File: hdl/stream_dft.sv
`timescale 1ns/100ps

module stream_dft (
    input  logic               clk_i,
    input  logic               reset_ni,
    input  logic               smp_valid_i,
    input  ofdm_pkg::sample_t  smp_data_i,
    input  logic               smp_first_i,
    output logic               bin_valid_o,
    output ofdm_pkg::dft_out_t bin_data_o,
    input  logic               bin_ready_i,
    output logic               overrun_o
);

    ofdm_pkg::bin_t     acc  [ofdm_pkg::FFT_LEN];  // one running sum per bin
    ofdm_pkg::bin_t     snap [ofdm_pkg::FFT_LEN];  // finished symbol waiting to drain
    ofdm_pkg::bin_t     prod [ofdm_pkg::FFT_LEN];
    ofdm_pkg::bin_idx_t smp_idx;                   // index expected for the next sample
    ofdm_pkg::bin_idx_t n_idx;
    logic               copy_due;
    logic               snap_valid;
    ofdm_pkg::bin_idx_t out_idx;
    logic               bin_xfer;

    assign n_idx = smp_first_i ? '0 : smp_idx;

    // sample times twiddle(m*n) for every bin m
    always_comb begin : twiddle_mult
        ofdm_pkg::twiddle_t tw;
        logic signed [ofdm_pkg::BIN_W+ofdm_pkg::TWIDDLE_FRAC-1:0] full_re;
        logic signed [ofdm_pkg::BIN_W+ofdm_pkg::TWIDDLE_FRAC-1:0] full_im;
        for (int m = 0; m < ofdm_pkg::FFT_LEN; m++) begin
            tw = ofdm_pkg::twiddle(m[ofdm_pkg::BIN_IDX_W-1:0] * n_idx);  // wraps modulo 16
            full_re = smp_data_i.re * tw.re - smp_data_i.im * tw.im;
            full_im = smp_data_i.re * tw.im + smp_data_i.im * tw.re;
            // taking the slice above bit 14 is the arithmetic shift right by 14
            prod[m].re = full_re[ofdm_pkg::BIN_W+ofdm_pkg::TWIDDLE_FRAC-1:ofdm_pkg::TWIDDLE_FRAC];
            prod[m].im = full_im[ofdm_pkg::BIN_W+ofdm_pkg::TWIDDLE_FRAC-1:ofdm_pkg::TWIDDLE_FRAC];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            for (int m = 0; m < ofdm_pkg::FFT_LEN; m++) begin
                acc[m] <= '0;
            end
            smp_idx  <= '0;
            copy_due <= 1'b0;
        end else begin
            copy_due <= smp_valid_i && (&n_idx);  // copy follows the 16th update
            if (smp_valid_i) smp_idx <= n_idx + 1'b1;
            for (int m = 0; m < ofdm_pkg::FFT_LEN; m++) begin
                if (copy_due) begin
                    acc[m] <= smp_valid_i ? prod[m] : '0;  // clear, keeping a new first sample
                end else if (smp_valid_i) begin
                    acc[m].re <= acc[m].re + prod[m].re;
                    acc[m].im <= acc[m].im + prod[m].im;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (copy_due) begin
            for (int m = 0; m < ofdm_pkg::FFT_LEN; m++) begin
                snap[m] <= acc[m];
            end
        end
    end

    assign bin_xfer = snap_valid && bin_ready_i;

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            snap_valid <= 1'b0;
            out_idx    <= '0;
            overrun_o  <= 1'b0;
        end else if (copy_due) begin
            snap_valid <= 1'b1;
            out_idx    <= '0;
            // handing over bin 15 in this same cycle is no loss
            if (snap_valid && !(bin_xfer && (&out_idx))) begin
                overrun_o <= 1'b1;
            end
        end else if (bin_xfer) begin
            out_idx <= out_idx + 1'b1;
            if (&out_idx) snap_valid <= 1'b0;
        end
    end

    assign bin_valid_o = snap_valid;
    assign bin_data_o = '{bin: snap[out_idx], idx: out_idx};

endmodule

// File: hdl/band_config.sv
`timescale 1ns/100ps

module band_config (
    input  logic                clk_i,
    input  logic                reset_ni,
    input  logic                cfg_we_i,
    input  ofdm_pkg::cfg_reg_e  cfg_addr_i,
    input  ofdm_pkg::cfg_data_t cfg_data_i,
    output ofdm_pkg::bin_idx_t  band_start_o,
    output ofdm_pkg::band_len_t band_len_o
);

    ofdm_pkg::bin_idx_t  start_new;
    ofdm_pkg::band_len_t room;      // bins from the current start up to bin 15
    ofdm_pkg::band_len_t room_new;  // same, counted from a start being written

    assign start_new = cfg_data_i[ofdm_pkg::BIN_IDX_W-1:0];
    assign room = ofdm_pkg::band_len_t'(ofdm_pkg::FFT_LEN) - ofdm_pkg::band_len_t'(band_start_o);
    assign room_new = ofdm_pkg::band_len_t'(ofdm_pkg::FFT_LEN) - ofdm_pkg::band_len_t'(start_new);

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            band_start_o <= ofdm_pkg::bin_idx_t'(ofdm_pkg::BAND_START_RST);
            band_len_o   <= ofdm_pkg::band_len_t'(ofdm_pkg::BAND_LEN_RST);
        end else if (cfg_we_i) begin
            case (cfg_addr_i)
                ofdm_pkg::REG_BAND_START: begin
                    band_start_o <= start_new;
                    // a moved start may push an old length past bin 15
                    if (band_len_o > room_new) band_len_o <= room_new;
                end
                ofdm_pkg::REG_BAND_LEN: begin
                    if (cfg_data_i > ofdm_pkg::cfg_data_t'(room)) begin
                        band_len_o <= room;
                    end else begin
                        band_len_o <= ofdm_pkg::band_len_t'(cfg_data_i);
                    end
                end
                default: band_len_o <= band_len_o;
            endcase
        end
    end

endmodule

// File: hdl/subcarrier_selector.sv
`timescale 1ns/100ps

module subcarrier_selector (
    input  logic                       clk_i,
    input  logic                       reset_ni,
    input  logic                       bin_valid_i,
    input  ofdm_pkg::dft_out_t         bin_data_i,
    output logic                       bin_ready_o,
    input  ofdm_pkg::bin_idx_t         band_start_i,
    input  ofdm_pkg::band_len_t        band_len_i,
    input  logic [ofdm_pkg::SYM_W-1:0] meta_sym_i,
    output logic                       meta_pop_o,
    input  logic                       credit_i,
    output logic                       out_valid_o,
    output ofdm_pkg::out_beat_t        out_beat_o
);

    ofdm_pkg::band_len_t         rel;  // position of the bin inside the window
    logic                        in_band;
    logic                        at_last;
    logic                        accept;
    logic                        send;
    logic [ofdm_pkg::CREDIT_W-1:0] credit_cnt;
    ofdm_pkg::bin_t              bin_q;
    logic [ofdm_pkg::SYM_W-1:0]  sym_q;
    ofdm_pkg::bin_idx_t          idx_q;
    logic                        last_q;

    assign rel = ofdm_pkg::band_len_t'(bin_data_i.idx) - ofdm_pkg::band_len_t'(band_start_i);
    assign in_band = (bin_data_i.idx >= band_start_i) && (rel < band_len_i);
    assign at_last = (rel == band_len_i - 1'b1);

    // out-of-band bins are taken and dropped at once, in-band ones wait for a credit
    assign bin_ready_o = !in_band || (credit_cnt != '0);
    assign accept = bin_valid_i && bin_ready_o;
    assign send = accept && in_band;
    assign meta_pop_o = accept && (&bin_data_i.idx);  // symbol is done with bin 15

    always_ff @(posedge clk_i) begin
        if (!reset_ni) begin
            credit_cnt  <= ofdm_pkg::OUT_CREDITS[ofdm_pkg::CREDIT_W-1:0];
            out_valid_o <= 1'b0;
            last_q      <= 1'b0;
        end else begin
            out_valid_o <= send;
            last_q      <= send && at_last;  // kept low between beats
            case ({credit_i, send})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;  // a return and a spend cancel
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (send) begin
            bin_q <= bin_data_i.bin;
            sym_q <= meta_sym_i;
            idx_q <= bin_data_i.idx;
        end
    end

    assign out_beat_o = '{bin: bin_q, sym: sym_q, idx: idx_q, last: last_q};

endmodule

// File: hdl/ofdm_demod_top.sv
`timescale 1ns/100ps

module ofdm_demod_top (
    input  logic                clk_i,
    input  logic                reset_ni,
    input  logic                in_valid_i,
    input  ofdm_pkg::sample_t   in_data_i,
    input  ofdm_pkg::in_user_t  in_user_i,
    input  logic                in_last_i,
    input  logic                cfg_we_i,
    input  ofdm_pkg::cfg_reg_e  cfg_addr_i,
    input  ofdm_pkg::cfg_data_t cfg_data_i,
    input  logic                credit_i,
    output logic                out_valid_o,
    output ofdm_pkg::out_beat_t out_beat_o,
    output logic                overrun_o
);

    logic                       smp_valid;
    ofdm_pkg::sample_t          smp_data;
    logic                       smp_first;
    logic                       meta_push;
    logic [ofdm_pkg::SYM_W-1:0] meta_sym_in;
    logic [ofdm_pkg::SYM_W-1:0] meta_sym_out;
    logic                       meta_pop;
    logic                       bin_valid;
    ofdm_pkg::dft_out_t         bin_data;
    logic                       bin_ready;
    ofdm_pkg::bin_idx_t         band_start;
    ofdm_pkg::band_len_t        band_len;

    cp_remover cp_remover_i (
        .clk_i, .reset_ni, .in_valid_i, .in_data_i, .in_user_i, .in_last_i,
        .smp_valid_o(smp_valid), .smp_data_o(smp_data), .smp_first_o(smp_first),
        .meta_push_o(meta_push), .meta_sym_o(meta_sym_in)
    );

    // the selector never pops an empty FIFO, so the flag stays internal
    symbol_meta_fifo symbol_meta_fifo_i (
        .clk_i, .reset_ni, .push_i(meta_push), .push_data_i(meta_sym_in),
        .pop_i(meta_pop), .pop_data_o(meta_sym_out), .empty_o()
    );

    stream_dft stream_dft_i (
        .clk_i, .reset_ni, .smp_valid_i(smp_valid), .smp_data_i(smp_data),
        .smp_first_i(smp_first), .bin_valid_o(bin_valid), .bin_data_o(bin_data),
        .bin_ready_i(bin_ready), .overrun_o
    );

    band_config band_config_i (
        .clk_i, .reset_ni, .cfg_we_i, .cfg_addr_i, .cfg_data_i,
        .band_start_o(band_start), .band_len_o(band_len)
    );

    subcarrier_selector subcarrier_selector_i (
        .clk_i, .reset_ni, .bin_valid_i(bin_valid), .bin_data_i(bin_data),
        .bin_ready_o(bin_ready), .band_start_i(band_start), .band_len_i(band_len),
        .meta_sym_i(meta_sym_out), .meta_pop_o(meta_pop), .credit_i,
        .out_valid_o, .out_beat_o
    );

endmodule

// File: verif/ofdm_demod_properties.sv
`timescale 1ns/100ps

module ofdm_demod_properties (
    input logic                          clk_i,
    input logic                          reset_ni,
    input logic                          out_valid_i,
    input logic                          last_i,
    input logic [ofdm_pkg::CREDIT_W-1:0] credit_cnt_i
);

    // a beat leaves one cycle after it was accepted with a credit in hand
    assert property (@(posedge clk_i) disable iff (!reset_ni)
        out_valid_i |-> $past(credit_cnt_i) != '0)
        else $error("beat sent while no credit was held");

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        credit_cnt_i <= ofdm_pkg::CREDIT_W'(ofdm_pkg::OUT_CREDITS))
        else $error("credit count above its initial value");

    assert property (@(posedge clk_i) disable iff (!reset_ni)
        last_i |-> out_valid_i)
        else $error("last flag without a valid beat");

endmodule

bind subcarrier_selector ofdm_demod_properties ofdm_demod_properties_i (
    .clk_i, .reset_ni, .out_valid_i(out_valid_o), .last_i(out_beat_o.last),
    .credit_cnt_i(credit_cnt)
);

// File: verif/ofdm_demod_tb.sv
`timescale 1ns/100ps

module ofdm_demod_tb;

    localparam int NUM_ROWS = 10;
    localparam int CYCLE_LIMIT = 64 * (NUM_ROWS + 2) + 200;  // two more symbols for overrun

    typedef struct packed {
        int                      sym;
        int                      cp;
        int                      extra;   // trailing repetition beats
        logic                    bw;      // write the band before this symbol
        int                      bstart;
        int                      blen;
        int                      hold;    // cycles without credit return after the 16th sample
        ofdm_pkg::sample_t [3:0] taps;    // samples at indices 0, 4, 8 and 12
    } row_t;

    logic                clk_i;
    logic                reset_ni;
    logic                in_valid_i;
    ofdm_pkg::sample_t   in_data_i;
    ofdm_pkg::in_user_t  in_user_i;
    logic                in_last_i;
    logic                cfg_we_i;
    ofdm_pkg::cfg_reg_e  cfg_addr_i;
    ofdm_pkg::cfg_data_t cfg_data_i;
    logic                credit_i;
    logic                out_valid_o;
    ofdm_pkg::out_beat_t out_beat_o;
    logic                overrun_o;

    row_t                rows [NUM_ROWS];
    ofdm_pkg::out_beat_t exp_q [$];
    int                  cycle = 0;
    int                  owed = 0;   // credits downstream still has to return
    int                  tb_credits = ofdm_pkg::OUT_CREDITS;
    int                  hold_from = 0;
    int                  hold_to = 0;
    int                  prev_cp = ofdm_pkg::CP_LEN_DEFAULT;
    int                  band_start = ofdm_pkg::BAND_START_RST;
    int                  band_len = ofdm_pkg::BAND_LEN_RST;
    logic                hold_all = 1'b0;
    logic                check_on = 1'b1;

    ofdm_demod_top ofdm_demod_top_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic stop_on_error(string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bin(string name, ofdm_pkg::bin_t got, ofdm_pkg::bin_t exp);
        if (got !== exp) stop_on_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) stop_on_error($sformatf("FAIL %s: got %h expected %h", name, got, exp));
    endtask

    task automatic check_beat(ofdm_pkg::out_beat_t got, ofdm_pkg::out_beat_t exp);
        check_bin("out_beat_o.bin", got.bin, exp.bin);
        check_flag("out_beat_o.last", got.last, exp.last);
        if (got !== exp) begin
            stop_on_error($sformatf("FAIL out_beat_o: got %h expected %h", got, exp));
        end
    endtask

    function automatic row_t make_row(int sym, int cp, int extra, logic bw, int bs, int bl,
                                      int hold, int r0, int i0, int r4, int i4,
                                      int r8, int i8, int r12, int i12);
        row_t r;
        r = '{sym: sym, cp: cp, extra: extra, bw: bw, bstart: bs, blen: bl, hold: hold,
              taps: '0};
        r.taps[0] = '{im: ofdm_pkg::SAMPLE_W'(i0), re: ofdm_pkg::SAMPLE_W'(r0)};
        r.taps[1] = '{im: ofdm_pkg::SAMPLE_W'(i4), re: ofdm_pkg::SAMPLE_W'(r4)};
        r.taps[2] = '{im: ofdm_pkg::SAMPLE_W'(i8), re: ofdm_pkg::SAMPLE_W'(r8)};
        r.taps[3] = '{im: ofdm_pkg::SAMPLE_W'(i12), re: ofdm_pkg::SAMPLE_W'(r12)};
        return r;
    endfunction

    // X[m] sums x[4t] times e^(-j*pi*m*t/2) where every factor is 1, -j, -1 or +j
    function automatic ofdm_pkg::bin_t expected_bin(row_t r, int m);
        ofdm_pkg::bin_t b;
        int re;
        int im;
        int xr;
        int xi;
        re = 0;
        im = 0;
        for (int t = 0; t < 4; t++) begin
            xr = $signed(r.taps[t].re);
            xi = $signed(r.taps[t].im);
            case ((m * t) % 4)
                0: begin
                    re += xr;
                    im += xi;
                end
                1: begin
                    re += xi;
                    im -= xr;
                end
                2: begin
                    re -= xr;
                    im -= xi;
                end
                default: begin
                    re -= xi;
                    im += xr;
                end
            endcase
        end
        b.re = ofdm_pkg::BIN_W'(re);
        b.im = ofdm_pkg::BIN_W'(im);
        return b;
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic idle(int n);
        repeat (n) begin
            next_cycle();
            in_valid_i = 1'b0;
        end
    endtask

    task automatic wait_drain();
        idle(1);
        while (exp_q.size() != 0) idle(1);
    endtask

    task automatic write_cfg(ofdm_pkg::cfg_reg_e addr, int value);
        next_cycle();
        in_valid_i = 1'b0;
        cfg_we_i   = 1'b1;
        cfg_addr_i = addr;
        cfg_data_i = ofdm_pkg::cfg_data_t'(value);
        next_cycle();
        cfg_we_i   = 1'b0;
    endtask

    task automatic drive_beat(ofdm_pkg::sample_t d, ofdm_pkg::in_user_t u, logic last);
        next_cycle();
        in_valid_i = 1'b1;
        in_data_i  = d;
        in_user_i  = u;
        in_last_i  = last;
    endtask

    task automatic send_row(row_t r);
        ofdm_pkg::in_user_t  u;
        ofdm_pkg::sample_t   d;
        ofdm_pkg::out_beat_t beat;
        int                  junk;
        if (r.bw) begin  // the band only moves once the previous symbol is out
            wait_drain();
            idle(20);
            write_cfg(ofdm_pkg::REG_BAND_START, r.bstart);
            write_cfg(ofdm_pkg::REG_BAND_LEN, r.blen);
            band_start = r.bstart;
            band_len = (r.blen > 16 - r.bstart) ? 16 - r.bstart : r.blen;
        end
        for (int m = band_start; m < band_start + band_len; m++) begin
            beat.bin  = expected_bin(r, m);
            beat.sym  = ofdm_pkg::SYM_W'(r.sym);
            beat.idx  = ofdm_pkg::BIN_IDX_W'(m);
            beat.last = (m == band_start + band_len - 1);
            exp_q.push_back(beat);
        end
        u = '{sym: ofdm_pkg::SYM_W'(r.sym), cp_len: ofdm_pkg::CP_LEN_W'(r.cp)};
        junk = r.cp - prev_cp / 2;  // the window opens half of the last prefix early
        repeat (junk) drive_beat($urandom, u, 1'b0);
        for (int n = 0; n < 16; n++) begin
            d = (n % 4 == 0) ? r.taps[n / 4] : '0;
            drive_beat(d, u, (n == 15) && (r.extra == 0));
        end
        hold_from = cycle;
        hold_to = cycle + r.hold;
        for (int e = 0; e < r.extra; e++) drive_beat($urandom, u, e == r.extra - 1);
        prev_cp = r.cp;
    endtask

    always @(posedge clk_i) begin
        cycle++;
        if (cycle >= CYCLE_LIMIT) stop_on_error($sformatf("timeout after %0d cycles", cycle));
    end

    // downstream returns one credit per cycle unless it is holding them back
    always @(posedge clk_i) begin
        #2;
        if (!hold_all && !(cycle > hold_from && cycle <= hold_to) && owed > 0) begin
            credit_i = 1'b1;
            owed--;
            tb_credits++;
        end else begin
            credit_i = 1'b0;
        end
    end

    always @(negedge clk_i) begin
        if (reset_ni && out_valid_o) begin
            if (tb_credits == 0) stop_on_error("output beat sent with no credit left");
            tb_credits--;
            owed++;
            if (check_on) begin
                if (exp_q.size() == 0) stop_on_error("output beat arrived with none expected");
                check_beat(out_beat_o, exp_q.pop_front());
            end
        end
        if (reset_ni && check_on) check_flag("overrun_o", overrun_o, 1'b0);
    end

    initial begin
        void'($urandom(73065));
        reset_ni   = 1'b0;
        in_valid_i = 1'b0;
        in_data_i  = '0;
        in_user_i  = '0;
        in_last_i  = 1'b0;
        cfg_we_i   = 1'b0;
        cfg_addr_i = ofdm_pkg::REG_BAND_START;
        cfg_data_i = '0;
        credit_i   = 1'b0;
        rows[0] = make_row(1, 16, 0, 0, 0, 0, 0, 1000, -500, 0, 0, 0, 0, 0, 0);
        rows[1] = make_row(2, 12, 3, 0, 0, 0, 0, 1000, -500, 0, 0, 0, 0, 0, 0);
        rows[2] = make_row(3, 10, 5, 0, 0, 0, 0, 1000, -500, 0, 0, 0, 0, 0, 0);
        rows[3] = make_row(4, 20, 2, 0, 0, 0, 0, 1000, -500, 0, 0, 0, 0, 0, 0);
        rows[4] = make_row(5, 16, 0, 1, 0, 16, 0, 100, 200, -300, 50, 700, -900, -20, 1234);
        rows[5] = make_row(6, 16, 1, 0, 0, 0, 0, -4000, 3000, 2500, -1500, 8000, 600,
                           -7000, -32768);
        rows[6] = make_row(7, 16, 0, 1, 12, 8, 0, 321, -123, 45, 678, -910, 11, 1213, -1415);
        rows[7] = make_row(8, 16, 40, 1, 0, 16, 30, 5000, 0, 0, 5000, -5000, 0, 0, -5000);
        rows[8] = make_row(9, 16, 0, 0, 0, 0, 0, 17, -17, 255, 1024, -2048, 99, 7, -3);
        rows[9] = make_row(10, 16, 2, 1, 4, 8, 0, 0, 0, 0, 0, 0, 0, 32767, 1);
        repeat (4) @(posedge clk_i);
        #2;
        reset_ni = 1'b1;
        foreach (rows[i]) send_row(rows[i]);
        wait_drain();
        idle(20);
        // credits stay withheld from here so the second symbol lands on undrained bins
        check_on = 1'b0;
        hold_all = 1'b1;
        send_row(make_row(11, 16, 0, 1, 0, 16, 0, 10, 20, 30, 40, 50, 60, 70, 80));
        idle(30);
        check_flag("overrun_o", overrun_o, 1'b0);
        send_row(make_row(12, 16, 0, 0, 0, 0, 0, 1, 2, 3, 4, 5, 6, 7, 8));
        while (!overrun_o) idle(1);
        repeat (20) begin
            idle(1);
            check_flag("overrun_o", overrun_o, 1'b1);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: list.f
hdl/ofdm_pkg.sv
hdl/cp_remover.sv
hdl/symbol_meta_fifo.sv
hdl/stream_dft.sv
hdl/band_config.sv
hdl/subcarrier_selector.sv
hdl/ofdm_demod_top.sv
verif/ofdm_demod_properties.sv
verif/ofdm_demod_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = ofdm_demod_tb
FILELIST  = list.f
SIM       = obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
